/* Bender.yml */
package:
  name: capture_top

sources:
  - verilog/board_pkg.sv
  - verilog/cell_locator.sv
  - verilog/stroke_recorder.sv
  - verilog/capture_regs.sv
  - verilog/capture_top.sv
  - target: test
    files:
      - sim/tb_capture_top.sv

/* capture_top.f */
verilog/board_pkg.sv
verilog/cell_locator.sv
verilog/stroke_recorder.sv
verilog/capture_regs.sv
verilog/capture_top.sv
sim/tb_capture_top.sv

/* sim/tb_capture_top.sv */
// The button is kept released around register writes, so the model
// may follow CTRL and STATUS writes one cycle late without a mismatch

`timescale 1ns/1ps
`default_nettype none

module tb_capture_top;

    logic        clk;
    logic        rst;
    logic [9:0]  mouse_x;
    logic [9:0]  mouse_y;
    logic        mouse_left;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        irq;

    // Stimulus table: raw x, raw y, button, cycles
    int tab_x[$];
    int tab_y[$];
    int tab_l[$];
    int tab_n[$];

    // Reference model
    logic [board_pkg::TRACK_WORDS*32-1:0] m_track;
    logic        m_enable;
    logic        m_drawing;
    logic        m_done;
    int          m_ticks;
    int          m_left;
    int          m_cx;
    int          m_cy;
    int          cx;
    int          cy;
    int          ox;
    int          oy;
    logic        inb;

    integer      seed;
    logic [31:0] st;
    int          dx;
    int          dy;

    capture_top i_capture_top (
        .clk        (clk),
        .rst        (rst),
        .mouse_x    (mouse_x),
        .mouse_y    (mouse_y),
        .mouse_left (mouse_left),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_sel     (wb_sel),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .irq        (irq)
    );

    always #4 clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================
    task automatic fail_run(input string what);
        begin
            $display("%s", what);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        begin
            assert (got === exp) else begin
                fail_run($sformatf("FAIL at %0t ns: %s = 0x%08h, expected 0x%08h",
                                   $time, name, got, exp));
            end
        end
    endtask

    // Mirror and map one raw point, high when it lies inside a cell
    function automatic logic map_point(input int raw_x, input int raw_y,
                                       output int px, output int py,
                                       output int qx, output int qy);
        int sx;
        int sy;
        begin
            sx = board_pkg::SCREEN_W - 1 - raw_x;
            sy = board_pkg::SCREEN_H - 1 - raw_y;
            px = (sx - board_pkg::BOARD_X0) / board_pkg::CELL_PITCH;
            qx = (sx - board_pkg::BOARD_X0) % board_pkg::CELL_PITCH;
            py = sy / board_pkg::CELL_PITCH;
            qy = sy % board_pkg::CELL_PITCH;
            map_point = raw_x < board_pkg::SCREEN_W && raw_y < board_pkg::SCREEN_H
                     && sx >= board_pkg::BOARD_X0 && sy >= 0
                     && px < board_pkg::GRID_N && py < board_pkg::GRID_N
                     && qx < board_pkg::CELL_SIZE && qy < board_pkg::CELL_SIZE;
        end
    endfunction

    // Cell y from bit 12, cell x from bit 8
    function automatic logic [31:0] status_exp(input logic drawing, input logic done);
        status_exp = (32'(m_cy) << 12) | (32'(m_cx) << 8)
                   | (32'(done) << 1) | 32'(drawing);
    endfunction

    function automatic logic [31:0] reg_addr(input logic [2:0] sel);
        reg_addr = {27'd0, sel, 2'b00};
    endfunction

    task automatic wb_access(input logic we, input logic [31:0] addr,
                             input logic [3:0] sel, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int n;
        begin
            @(posedge clk);
            wb_cyc   <= 1'b1;
            wb_stb   <= 1'b1;
            wb_we    <= we;
            wb_adr   <= addr;
            wb_dat_i <= wdata;
            wb_sel   <= sel;
            n = 0;
            @(posedge clk);
            while (wb_ack !== 1'b1) begin
                n++;
                if (n > 16) begin
                    fail_run("Wishbone ack did not arrive within 16 cycles");
                end
                @(posedge clk);
            end
            rdata = wb_dat_o;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel);
        logic [31:0] unused;
        begin
            wb_access(1'b1, addr, sel, data, unused);
        end
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
        begin
            wb_access(1'b0, addr, 4'hf, 32'd0, data);
        end
    endtask

    task automatic add_row(input int x, input int y, input int l, input int n);
        begin
            tab_x.push_back(x);
            tab_y.push_back(y);
            tab_l.push_back(l);
            tab_n.push_back(n);
        end
    endtask

    task automatic apply_rows(input int first, input int last);
        begin
            for (int i = first; i <= last; i++) begin
                @(posedge clk);
                mouse_x    <= 10'(tab_x[i]);
                mouse_y    <= 10'(tab_y[i]);
                mouse_left <= tab_l[i][0];
                repeat (tab_n[i] - 1) @(posedge clk);
            end
        end
    endtask

    // Held button wandering around the middle of cell (3,2)
    task automatic apply_jitter(input int cycles);
        begin
            repeat (cycles) begin
                @(posedge clk);
                dx = $random(seed) % 9;
                dy = $random(seed) % 9;
                mouse_x    <= 10'(294 + dx);
                mouse_y    <= 10'(347 + dy);
                mouse_left <= 1'b1;
            end
        end
    endtask

    task automatic expect_idle(input int reads);
        begin
            for (int i = 0; i < reads; i++) begin
                wb_read(reg_addr(board_pkg::REG_STATUS), st);
                check_value("STATUS.drawing", {31'd0, st[0]}, 32'd0);
            end
        end
    endtask

    task automatic wait_done();
        int n;
        begin
            n = 0;
            st = '0;
            while (st[1] !== 1'b1) begin
                n++;
                if (n > 100) begin
                    fail_run("STATUS.done was not seen within 100 reads");
                end
                wb_read(reg_addr(board_pkg::REG_STATUS), st);
            end
        end
    endtask

    task automatic check_bitmap();
        logic [31:0] d;
        begin
            for (int w = 0; w < board_pkg::TRACK_WORDS; w++) begin
                wb_read(32'h200 + 32'(w) * 4, d);
                check_value($sformatf("track word %0d", w), d, m_track[w*32 +: 32]);
            end
        end
    endtask

    // ============================================================
    // Reference model, fed with the samples the DUT sees each edge
    // ============================================================
    always @(posedge clk) begin
        if (rst) begin
            m_drawing = 1'b0;
            m_done    = 1'b0;
            m_track   = '0;
            m_cx      = 0;
            m_cy      = 0;
        end else begin
            inb = map_point(mouse_x, mouse_y, cx, cy, ox, oy);
            if (m_drawing) begin
                if (mouse_left && inb && cx == m_cx && cy == m_cy) begin
                    m_track[oy * board_pkg::CELL_SIZE + ox] = 1'b1;
                end
                m_left = m_left - 1;
                if (m_left == 0) begin
                    m_drawing = 1'b0;
                    m_done    = 1'b1;
                end
            end else if (m_enable && !m_done && mouse_left && inb) begin
                m_drawing = 1'b1;
                m_left    = m_ticks;
                m_cx      = cx;
                m_cy      = cy;
                m_track   = '0;
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mouse_x = 10'd0;
        mouse_y = 10'd0;
        mouse_left = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        wb_sel = '0;
        m_enable = 1'b0;
        m_ticks = 150_000_000;
        seed = 32'h6757;

        // Rows 0-1: press inside a cell with enable low
        add_row(310, 368, 1, 3);
        add_row(310, 368, 0, 2);
        // Rows 2-7: left of board, gap column, off screen, gap row, off screen
        add_row(539, 368, 1, 3);
        add_row(268, 368, 1, 3);
        add_row(700, 368, 1, 3);
        add_row(310, 427, 1, 3);
        add_row(310, 500, 1, 3);
        add_row(310, 368, 0, 2);
        // Rows 8-15: stroke in cell (3,2) with a release, a neighbor and a gap
        add_row(310, 368, 1, 1);
        add_row(310, 368, 1, 3);
        add_row(305, 360, 1, 4);
        add_row(300, 350, 0, 3);
        add_row(266, 340, 1, 2);
        add_row(268, 340, 1, 2);
        add_row(290, 330, 1, 5);
        add_row(269, 322, 1, 3);
        // Row 16 release; rows 17-19 move while done
        add_row(294, 347, 0, 1);
        add_row(300, 350, 1, 3);
        add_row(100, 150, 1, 3);
        add_row(294, 347, 0, 1);
        // Rows 20-25: second stroke in cell (7,6)
        add_row(100, 150, 1, 1);
        add_row(100, 150, 1, 2);
        add_row(95, 140, 1, 3);
        add_row(60, 120, 1, 2);
        add_row(108, 161, 1, 2);
        add_row(100, 150, 0, 1);

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        wb_read(reg_addr(board_pkg::REG_STATUS), st);
        check_value("STATUS", st, 32'd0);
        check_value("irq", {31'd0, irq}, 32'd0);
        check_bitmap();

        wb_write(reg_addr(board_pkg::REG_WINDOW), 32'd0, 4'hf);
        wb_read(reg_addr(board_pkg::REG_WINDOW), st);
        check_value("WINDOW", st, 32'd1);
        // No byte lane selected, the whole word is still written
        wb_write(reg_addr(board_pkg::REG_WINDOW), 32'd64, 4'h0);
        wb_read(reg_addr(board_pkg::REG_WINDOW), st);
        check_value("WINDOW", st, 32'd64);
        m_ticks = 64;

        apply_rows(0, 1);
        expect_idle(6);
        wb_write(reg_addr(board_pkg::REG_CTRL), 32'd3, 4'hf);
        m_enable = 1'b1;
        apply_rows(2, 7);
        expect_idle(6);

        // First stroke
        apply_rows(8, 15);
        apply_jitter(20);
        apply_rows(16, 16);
        wb_read(reg_addr(board_pkg::REG_STATUS), st);
        check_value("STATUS.drawing", {31'd0, st[0]}, 32'd1);
        wait_done();
        check_value("STATUS", st, status_exp(1'b0, 1'b1));
        check_value("irq", {31'd0, irq}, 32'd1);
        check_bitmap();

        // Frozen while done
        apply_rows(17, 19);
        wb_read(reg_addr(board_pkg::REG_STATUS), st);
        check_value("STATUS", st, status_exp(1'b0, 1'b1));
        check_bitmap();

        wb_write(reg_addr(board_pkg::REG_STATUS), 32'd2, 4'hf);
        m_done = 1'b0;
        wb_read(reg_addr(board_pkg::REG_STATUS), st);
        check_value("STATUS", st, status_exp(1'b0, 1'b0));
        check_value("irq", {31'd0, irq}, 32'd0);

        // Second stroke replaces the first bitmap
        apply_rows(20, 25);
        wait_done();
        check_value("STATUS", st, status_exp(1'b0, 1'b1));
        check_bitmap();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/board_pkg.sv */
// Geometry is fixed to one 9x9 board on a 640x480 screen
// Bitmap words sit at byte offset 0x200, registers below it

`default_nettype none

package board_pkg;

    // ============================================================
    // Screen and board geometry
    // ============================================================
    localparam int SCREEN_W   = 640;
    localparam int SCREEN_H   = 480;
    localparam int BOARD_X0   = 160;
    localparam int CELL_SIZE  = 52;
    localparam int CELL_PITCH = 53;
    localparam int GRID_N     = 9;

    localparam int COORD_W = 10;
    localparam int CELL_W  = 4;

    // Stroke bitmap, one bit per pixel of a cell
    localparam int TRACK_BITS  = CELL_SIZE * CELL_SIZE;
    localparam int TRACK_WORDS = (TRACK_BITS + 31) / 32;
    localparam int WORD_IDX_W  = 7;

    // ============================================================
    // Register map
    // ============================================================
    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_WINDOW = 3'd1;
    localparam logic [2:0] REG_STATUS = 3'd2;

    localparam logic [31:0] DEFAULT_DRAW_TICKS = 32'd150_000_000;

    // Word address, bits 9:2 of the byte address
    typedef union packed {
        struct packed {
            logic                  is_track;
            logic [WORD_IDX_W-1:0] word_idx;
        } track;
        struct packed {
            logic       is_track;
            logic [3:0] pad;
            logic [2:0] reg_sel;
        } regs;
    } wb_addr_u;

endpackage

`default_nettype wire

/* verilog/capture_regs.sv */
// Wishbone classic slave with one ack per request and read data valid with ack
// Byte selects are ignored and every write updates the whole word

`timescale 1ns/1ps
`default_nettype none

module capture_regs (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              wb_cyc,
    input  wire logic                              wb_stb,
    input  wire logic                              wb_we,
    input  wire logic [31:0]                       wb_adr,
    input  wire logic [31:0]                       wb_dat_i,
    input  wire logic [3:0]                        wb_sel,
    input  wire logic                              drawing,
    input  wire logic                              done,
    input  wire logic                              done_pulse,
    input  wire logic [board_pkg::CELL_W-1:0]      lat_cell_x,
    input  wire logic [board_pkg::CELL_W-1:0]      lat_cell_y,
    input  wire logic [31:0]                       track_word,
    output logic [31:0]                            wb_dat_o,
    output logic                                   wb_ack,
    output logic                                   irq,
    output logic                                   enable,
    output logic [31:0]                            draw_ticks,
    output logic                                   done_clear,
    output logic [board_pkg::WORD_IDX_W-1:0]       word_idx
);

    board_pkg::wb_addr_u addr;

    logic        irq_en;
    logic        req;
    logic        wr;
    logic        reg_hit;
    logic [31:0] status_word;
    logic [31:0] rd_data;

    // ============================================================
    // Address decode
    // ============================================================
    assign addr = wb_adr[9:2];

    // Second cycle of a held strobe is not a new request
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign wr  = req && wb_we;

    assign reg_hit  = !addr.regs.is_track && (addr.regs.pad == 4'd0);
    assign word_idx = addr.track.word_idx;

    assign status_word = {16'd0, lat_cell_y, lat_cell_x, 6'd0, done, drawing};

    always_comb begin
        rd_data = '0;
        if (addr.track.is_track) begin
            rd_data = track_word;
        end else if (reg_hit) begin
            case (addr.regs.reg_sel)
                board_pkg::REG_CTRL:   rd_data = {30'd0, irq_en, enable};
                board_pkg::REG_WINDOW: rd_data = draw_ticks;
                board_pkg::REG_STATUS: rd_data = status_word;
                default:               rd_data = '0;
            endcase
        end
    end

    // ============================================================
    // Handshake and registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            enable     <= 1'b0;
            irq_en     <= 1'b0;
            draw_ticks <= board_pkg::DEFAULT_DRAW_TICKS;
            done_clear <= 1'b0;
        end else begin
            wb_ack     <= req;
            done_clear <= 1'b0;

            if (wr && reg_hit) begin
                case (addr.regs.reg_sel)
                    board_pkg::REG_CTRL: begin
                        enable <= wb_dat_i[0];
                        irq_en <= wb_dat_i[1];
                    end
                    board_pkg::REG_WINDOW: begin
                        // Zero-length window is not allowed
                        draw_ticks <= (wb_dat_i == 32'd0) ? 32'd1 : wb_dat_i;
                    end
                    board_pkg::REG_STATUS: begin
                        done_clear <= wb_dat_i[1];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read data captured on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    // ============================================================
    // Interrupt
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else if (done_pulse && irq_en) begin
            irq <= 1'b1;
        end else if (done_clear || !irq_en) begin
            irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/capture_top.sv */
// Stroke capture for one board cell, Wishbone classic slave
// Mouse inputs are sampled every cycle with no synchronizer

`timescale 1ns/1ps
`default_nettype none

module capture_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [board_pkg::COORD_W-1:0] mouse_x,
    input  wire logic [board_pkg::COORD_W-1:0] mouse_y,
    input  wire logic                          mouse_left,
    input  wire logic                          wb_cyc,
    input  wire logic                          wb_stb,
    input  wire logic                          wb_we,
    input  wire logic [31:0]                   wb_adr,
    input  wire logic [31:0]                   wb_dat_i,
    input  wire logic [3:0]                    wb_sel,
    output logic [31:0]                        wb_dat_o,
    output logic                               wb_ack,
    output logic                               irq
);

    logic                                    in_board;
    logic [board_pkg::CELL_W-1:0]            cell_x;
    logic [board_pkg::CELL_W-1:0]            cell_y;
    logic [$clog2(board_pkg::CELL_SIZE)-1:0] off_x;
    logic [$clog2(board_pkg::CELL_SIZE)-1:0] off_y;

    logic                                    enable;
    logic [31:0]                             draw_ticks;
    logic                                    done_clear;
    logic [board_pkg::WORD_IDX_W-1:0]        word_idx;

    logic                                    drawing;
    logic                                    done;
    logic                                    done_pulse;
    logic [board_pkg::CELL_W-1:0]            lat_cell_x;
    logic [board_pkg::CELL_W-1:0]            lat_cell_y;
    logic [31:0]                             track_word;

    cell_locator i_cell_locator (
        .mouse_x  (mouse_x),
        .mouse_y  (mouse_y),
        .in_board (in_board),
        .cell_x   (cell_x),
        .cell_y   (cell_y),
        .off_x    (off_x),
        .off_y    (off_y)
    );

    stroke_recorder i_stroke_recorder (
        .clk        (clk),
        .rst        (rst),
        .mouse_left (mouse_left),
        .in_board   (in_board),
        .cell_x     (cell_x),
        .cell_y     (cell_y),
        .off_x      (off_x),
        .off_y      (off_y),
        .enable     (enable),
        .draw_ticks (draw_ticks),
        .done_clear (done_clear),
        .word_idx   (word_idx),
        .drawing    (drawing),
        .done       (done),
        .done_pulse (done_pulse),
        .lat_cell_x (lat_cell_x),
        .lat_cell_y (lat_cell_y),
        .track_word (track_word)
    );

    capture_regs i_capture_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_sel     (wb_sel),
        .drawing    (drawing),
        .done       (done),
        .done_pulse (done_pulse),
        .lat_cell_x (lat_cell_x),
        .lat_cell_y (lat_cell_y),
        .track_word (track_word),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .irq        (irq),
        .enable     (enable),
        .draw_ticks (draw_ticks),
        .done_clear (done_clear),
        .word_idx   (word_idx)
    );

endmodule

`default_nettype wire

/* verilog/cell_locator.sv */
// Mouse coordinates are raw, with (0,0) at the bottom-right corner
// Purely combinational; gap pixels between cells report in_board low

`timescale 1ns/1ps
`default_nettype none

module cell_locator (
    input  wire logic [board_pkg::COORD_W-1:0]             mouse_x,
    input  wire logic [board_pkg::COORD_W-1:0]             mouse_y,
    output logic                                           in_board,
    output logic [board_pkg::CELL_W-1:0]                   cell_x,
    output logic [board_pkg::CELL_W-1:0]                   cell_y,
    output logic [$clog2(board_pkg::CELL_SIZE)-1:0]        off_x,
    output logic [$clog2(board_pkg::CELL_SIZE)-1:0]        off_y
);

    logic x_ok;
    logic y_ok;

    // Mirror one axis, pick the cell and the offset inside it.
    // Returns high when the pixel lies inside a cell.
    function automatic logic map_axis(
        input  logic [board_pkg::COORD_W-1:0]            raw,
        input  int                                       extent,
        input  int                                       origin,
        output logic [board_pkg::CELL_W-1:0]             idx,
        output logic [$clog2(board_pkg::CELL_SIZE)-1:0]  off
    );
        logic [board_pkg::COORD_W-1:0] pos;
        logic [board_pkg::COORD_W-1:0] rel;
        logic [board_pkg::COORD_W-1:0] rem;
        logic                          on_screen;
        logic                          past_origin;
        begin
            on_screen   = raw < extent;
            pos         = board_pkg::COORD_W'(extent - 1 - raw);
            past_origin = pos >= origin;
            rel         = board_pkg::COORD_W'(pos - origin);

            // Count how many pitch multiples lie below the offset
            idx = '0;
            for (int k = 1; k < board_pkg::GRID_N; k++) begin
                if (rel >= k * board_pkg::CELL_PITCH) begin
                    idx = board_pkg::CELL_W'(k);
                end
            end

            rem = board_pkg::COORD_W'(rel - idx * board_pkg::CELL_PITCH);
            off = rem[$clog2(board_pkg::CELL_SIZE)-1:0];

            map_axis = on_screen && past_origin
                    && (rel < board_pkg::GRID_N * board_pkg::CELL_PITCH)
                    && (rem != board_pkg::CELL_SIZE);
        end
    endfunction

    // Board spans from column BOARD_X0 and from row 0
    always_comb begin
        x_ok = map_axis(mouse_x, board_pkg::SCREEN_W, board_pkg::BOARD_X0,
                        cell_x, off_x);
        y_ok = map_axis(mouse_y, board_pkg::SCREEN_H, 0,
                        cell_y, off_y);
    end

    assign in_board = x_ok && y_ok;

endmodule

`default_nettype wire

/* verilog/stroke_recorder.sv */
// Records one stroke per window into a 52x52 bitmap
// draw_ticks must be at least 1; the register block guarantees it

`timescale 1ns/1ps
`default_nettype none

module stroke_recorder (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic                                     mouse_left,
    input  wire logic                                     in_board,
    input  wire logic [board_pkg::CELL_W-1:0]             cell_x,
    input  wire logic [board_pkg::CELL_W-1:0]             cell_y,
    input  wire logic [$clog2(board_pkg::CELL_SIZE)-1:0]  off_x,
    input  wire logic [$clog2(board_pkg::CELL_SIZE)-1:0]  off_y,
    input  wire logic                                     enable,
    input  wire logic [31:0]                              draw_ticks,
    input  wire logic                                     done_clear,
    input  wire logic [board_pkg::WORD_IDX_W-1:0]         word_idx,
    output logic                                          drawing,
    output logic                                          done,
    output logic                                          done_pulse,
    output logic [board_pkg::CELL_W-1:0]                  lat_cell_x,
    output logic [board_pkg::CELL_W-1:0]                  lat_cell_y,
    output logic [31:0]                                   track_word
);

    logic [board_pkg::TRACK_BITS-1:0]       track;
    logic [board_pkg::TRACK_WORDS*32-1:0]   track_ext;
    logic [31:0]                            count;
    logic [$clog2(board_pkg::TRACK_BITS)-1:0] bit_idx;

    logic start;
    logic hit;
    logic window_end;

    // ============================================================
    // Control conditions
    // ============================================================

    // Idle means neither drawing nor holding a finished stroke
    assign start = enable && !drawing && !done && mouse_left && in_board;

    // Pointer must stay inside the latched cell
    assign hit = drawing && mouse_left && in_board
              && (cell_x == lat_cell_x) && (cell_y == lat_cell_y);

    assign window_end = drawing && (count >= draw_ticks - 32'd1);

    // Row-major index inside the cell
    assign bit_idx = ($clog2(board_pkg::TRACK_BITS))'(
                         off_y * board_pkg::CELL_SIZE + off_x);

    // ============================================================
    // State, window counter and bitmap
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            drawing    <= 1'b0;
            done       <= 1'b0;
            done_pulse <= 1'b0;
            count      <= '0;
            lat_cell_x <= '0;
            lat_cell_y <= '0;
            track      <= '0;
        end else begin
            done_pulse <= 1'b0;

            if (start) begin
                drawing    <= 1'b1;
                count      <= '0;
                lat_cell_x <= cell_x;
                lat_cell_y <= cell_y;
                track      <= '0;
            end else if (drawing) begin
                if (hit) begin
                    track[bit_idx] <= 1'b1;
                end

                if (window_end) begin
                    drawing    <= 1'b0;
                    done       <= 1'b1;
                    done_pulse <= 1'b1;
                end else begin
                    count <= count + 32'd1;
                end
            end else if (done && done_clear) begin
                done <= 1'b0;
            end
        end
    end

    // ============================================================
    // Bitmap word readout
    // ============================================================

    // Last word is padded with zeros past bit 2703
    assign track_ext = {{(board_pkg::TRACK_WORDS * 32 - board_pkg::TRACK_BITS){1'b0}},
                        track};

    always_comb begin
        if (word_idx < board_pkg::TRACK_WORDS) begin
            track_word = track_ext[word_idx * 32 +: 32];
        end else begin
            track_word = '0;
        end
    end

endmodule

`default_nettype wire
